//--- hdl/decode_pkg.sv
package decode_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    localparam logic [reg_addr_w-1:0] link_reg = 5'd31;

    // primary opcodes
    localparam logic [5:0] op_special = 6'h00;
    localparam logic [5:0] op_regimm  = 6'h01;
    localparam logic [5:0] op_j       = 6'h02;
    localparam logic [5:0] op_jal     = 6'h03;
    localparam logic [5:0] op_beq     = 6'h04;
    localparam logic [5:0] op_bne     = 6'h05;
    localparam logic [5:0] op_blez    = 6'h06;
    localparam logic [5:0] op_bgtz    = 6'h07;
    localparam logic [5:0] op_addiu   = 6'h09;
    localparam logic [5:0] op_slti    = 6'h0a;
    localparam logic [5:0] op_sltiu   = 6'h0b;
    localparam logic [5:0] op_andi    = 6'h0c;
    localparam logic [5:0] op_ori     = 6'h0d;
    localparam logic [5:0] op_xori    = 6'h0e;
    localparam logic [5:0] op_lui     = 6'h0f;
    localparam logic [5:0] op_lw      = 6'h23;
    localparam logic [5:0] op_sw      = 6'h2b;

    // function field of special
    localparam logic [5:0] fn_sll     = 6'h00;
    localparam logic [5:0] fn_srl     = 6'h02;
    localparam logic [5:0] fn_sra     = 6'h03;
    localparam logic [5:0] fn_jr      = 6'h08;
    localparam logic [5:0] fn_jalr    = 6'h09;
    localparam logic [5:0] fn_syscall = 6'h0c;
    localparam logic [5:0] fn_break   = 6'h0d;
    localparam logic [5:0] fn_addu    = 6'h21;
    localparam logic [5:0] fn_subu    = 6'h23;
    localparam logic [5:0] fn_and     = 6'h24;
    localparam logic [5:0] fn_or      = 6'h25;
    localparam logic [5:0] fn_xor     = 6'h26;
    localparam logic [5:0] fn_nor     = 6'h27;
    localparam logic [5:0] fn_slt     = 6'h2a;
    localparam logic [5:0] fn_sltu    = 6'h2b;

    localparam logic [4:0] rt_bltz = 5'h00;
    localparam logic [4:0] rt_bgez = 5'h01;

    localparam logic [4:0] exc_adel = 5'd4;
    localparam logic [4:0] exc_sys  = 5'd8;
    localparam logic [4:0] exc_bp   = 5'd9;
    localparam logic [4:0] exc_ri   = 5'd10;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_slt, alu_sltu, alu_and, alu_nor,
        alu_or, alu_xor, alu_sll, alu_srl, alu_sra, alu_lui
    } alu_op_e;

    typedef enum logic [1:0] {
        src2_reg, src2_simm, src2_uimm, src2_const8
    } src2_sel_e;

    typedef enum logic [3:0] {
        br_none, br_beq, br_bne, br_bgez, br_bltz, br_bgtz, br_blez, br_jimm, br_jreg
    } br_kind_e;

    typedef struct packed {
        logic [xlen-1:0] pc;
        logic [xlen-1:0] inst;
        logic            adel;
    } fetch_pkt_t;

    typedef struct packed {
        logic                  we;
        logic [reg_addr_w-1:0] addr;
        logic [xlen-1:0]       data;
    } wb_write_t;

    typedef struct packed {
        logic            rs_sel;
        logic            rt_sel;
        logic [xlen-1:0] data;
    } fwd_t;

    typedef struct packed {
        logic            taken;
        logic [xlen-1:0] target;
    } branch_t;

    typedef struct packed {
        alu_op_e               alu_op;
        logic                  src1_is_sa;
        logic                  src1_is_pc;
        src2_sel_e             src2_sel;
        logic                  gr_we;
        logic                  mem_read;
        logic                  mem_write;
        logic [reg_addr_w-1:0] dest;
        logic [15:0]           imm;
        br_kind_e              br_kind;
        logic                  exc;
        logic [4:0]            exc_code;
    } dec_ctrl_t;

    typedef struct packed {
        dec_ctrl_t       ctrl;
        logic [xlen-1:0] rs_value;
        logic [xlen-1:0] rt_value;
        logic [xlen-1:0] pc;
    } ex_pkt_t;

endpackage

//--- hdl/decode_pipe_reg.sv
`timescale 1ns/1ps

module decode_pipe_reg (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   flush,
    input  logic                   in_valid,
    output logic                   in_ready,
    input  decode_pkg::fetch_pkt_t in_pkt,
    output logic                   out_valid,
    input  logic                   out_ready,
    output decode_pkg::fetch_pkt_t out_pkt
);

    logic                   valid_q;
    decode_pkg::fetch_pkt_t pkt_q;

    // accept when empty or when the held packet leaves this cycle
    assign in_ready = ~valid_q | out_ready;

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            valid_q <= 1'b0;
        end else if (in_ready) begin
            valid_q <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            pkt_q <= in_pkt;
        end
    end

    assign out_valid = valid_q;
    assign out_pkt   = pkt_q;

endmodule

//--- hdl/inst_decoder.sv
`timescale 1ns/1ps

module inst_decoder (
    input  decode_pkg::fetch_pkt_t pkt,
    output decode_pkg::dec_ctrl_t  ctrl
);

    logic [5:0]  op;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [4:0]  rd;
    logic [4:0]  sa;
    logic [5:0]  func;
    logic [15:0] imm;

    logic special;
    logic r_type;
    logic inst_addu, inst_subu, inst_slt, inst_sltu;
    logic inst_and, inst_or, inst_xor, inst_nor;
    logic inst_sll, inst_srl, inst_sra;
    logic inst_addiu, inst_slti, inst_sltiu, inst_andi, inst_ori, inst_xori, inst_lui;
    logic inst_lw, inst_sw;
    logic inst_beq, inst_bne, inst_bgez, inst_bltz, inst_bgtz, inst_blez;
    logic inst_j, inst_jal, inst_jr, inst_jalr;
    logic inst_syscall, inst_break, inst_nop;
    logic is_cond_branch;
    logic dst_is_rt;
    logic reserved;

    assign op   = pkt.inst[31:26];
    assign rs   = pkt.inst[25:21];
    assign rt   = pkt.inst[20:16];
    assign rd   = pkt.inst[15:11];
    assign sa   = pkt.inst[10:6];
    assign func = pkt.inst[5:0];
    assign imm  = pkt.inst[15:0];

    assign special = (op == decode_pkg::op_special);
    // three-register ops need a zero shift field
    assign r_type  = special && (sa == 5'd0);

    assign inst_addu  = r_type && (func == decode_pkg::fn_addu);
    assign inst_subu  = r_type && (func == decode_pkg::fn_subu);
    assign inst_slt   = r_type && (func == decode_pkg::fn_slt);
    assign inst_sltu  = r_type && (func == decode_pkg::fn_sltu);
    assign inst_and   = r_type && (func == decode_pkg::fn_and);
    assign inst_or    = r_type && (func == decode_pkg::fn_or);
    assign inst_xor   = r_type && (func == decode_pkg::fn_xor);
    assign inst_nor   = r_type && (func == decode_pkg::fn_nor);
    assign inst_sll   = special && (rs == 5'd0) && (func == decode_pkg::fn_sll);
    assign inst_srl   = special && (rs == 5'd0) && (func == decode_pkg::fn_srl);
    assign inst_sra   = special && (rs == 5'd0) && (func == decode_pkg::fn_sra);
    assign inst_jr    = r_type && (rt == 5'd0) && (rd == 5'd0) && (func == decode_pkg::fn_jr);
    assign inst_jalr  = r_type && (rt == 5'd0) && (func == decode_pkg::fn_jalr);
    assign inst_syscall = special && (func == decode_pkg::fn_syscall);
    assign inst_break   = special && (func == decode_pkg::fn_break);
    assign inst_nop     = (pkt.inst == 32'h0);

    assign inst_addiu = (op == decode_pkg::op_addiu);
    assign inst_slti  = (op == decode_pkg::op_slti);
    assign inst_sltiu = (op == decode_pkg::op_sltiu);
    assign inst_andi  = (op == decode_pkg::op_andi);
    assign inst_ori   = (op == decode_pkg::op_ori);
    assign inst_xori  = (op == decode_pkg::op_xori);
    assign inst_lui   = (op == decode_pkg::op_lui) && (rs == 5'd0);
    assign inst_lw    = (op == decode_pkg::op_lw);
    assign inst_sw    = (op == decode_pkg::op_sw);
    assign inst_beq   = (op == decode_pkg::op_beq);
    assign inst_bne   = (op == decode_pkg::op_bne);
    assign inst_bgez  = (op == decode_pkg::op_regimm) && (rt == decode_pkg::rt_bgez);
    assign inst_bltz  = (op == decode_pkg::op_regimm) && (rt == decode_pkg::rt_bltz);
    assign inst_bgtz  = (op == decode_pkg::op_bgtz) && (rt == 5'd0);
    assign inst_blez  = (op == decode_pkg::op_blez) && (rt == 5'd0);
    assign inst_j     = (op == decode_pkg::op_j);
    assign inst_jal   = (op == decode_pkg::op_jal);

    assign is_cond_branch = inst_beq | inst_bne | inst_bgez | inst_bltz | inst_bgtz | inst_blez;
    assign dst_is_rt = inst_addiu | inst_slti | inst_sltiu | inst_andi | inst_ori | inst_xori
                     | inst_lui | inst_lw;

    assign reserved = ~(inst_addu | inst_subu | inst_slt | inst_sltu | inst_and | inst_or
                      | inst_xor | inst_nor | inst_sll | inst_srl | inst_sra | dst_is_rt
                      | inst_sw | is_cond_branch | inst_j | inst_jal | inst_jr | inst_jalr
                      | inst_syscall | inst_break | inst_nop);

    always_comb begin
        ctrl.alu_op = decode_pkg::alu_add;
        if (inst_subu) ctrl.alu_op = decode_pkg::alu_sub;
        if (inst_slt | inst_slti) ctrl.alu_op = decode_pkg::alu_slt;
        if (inst_sltu | inst_sltiu) ctrl.alu_op = decode_pkg::alu_sltu;
        if (inst_and | inst_andi) ctrl.alu_op = decode_pkg::alu_and;
        if (inst_nor) ctrl.alu_op = decode_pkg::alu_nor;
        if (inst_or | inst_ori) ctrl.alu_op = decode_pkg::alu_or;
        if (inst_xor | inst_xori) ctrl.alu_op = decode_pkg::alu_xor;
        if (inst_sll) ctrl.alu_op = decode_pkg::alu_sll;
        if (inst_srl) ctrl.alu_op = decode_pkg::alu_srl;
        if (inst_sra) ctrl.alu_op = decode_pkg::alu_sra;
        if (inst_lui) ctrl.alu_op = decode_pkg::alu_lui;

        ctrl.src1_is_sa = inst_sll | inst_srl | inst_sra;
        // link value is pc plus 8
        ctrl.src1_is_pc = inst_jal | inst_jalr;

        ctrl.src2_sel = decode_pkg::src2_reg;
        if (inst_addiu | inst_slti | inst_sltiu | inst_lui | inst_lw | inst_sw)
            ctrl.src2_sel = decode_pkg::src2_simm;
        if (inst_andi | inst_ori | inst_xori) ctrl.src2_sel = decode_pkg::src2_uimm;
        if (inst_jal | inst_jalr) ctrl.src2_sel = decode_pkg::src2_const8;

        ctrl.gr_we = ~(inst_sw | is_cond_branch | inst_j | inst_jr | inst_syscall
                     | inst_break | inst_nop | reserved);
        ctrl.mem_read  = inst_lw;
        ctrl.mem_write = inst_sw;

        if (inst_jal) ctrl.dest = decode_pkg::link_reg;
        else if (dst_is_rt) ctrl.dest = rt;
        else ctrl.dest = rd;

        ctrl.imm = imm;

        ctrl.br_kind = decode_pkg::br_none;
        if (inst_beq) ctrl.br_kind = decode_pkg::br_beq;
        if (inst_bne) ctrl.br_kind = decode_pkg::br_bne;
        if (inst_bgez) ctrl.br_kind = decode_pkg::br_bgez;
        if (inst_bltz) ctrl.br_kind = decode_pkg::br_bltz;
        if (inst_bgtz) ctrl.br_kind = decode_pkg::br_bgtz;
        if (inst_blez) ctrl.br_kind = decode_pkg::br_blez;
        if (inst_j | inst_jal) ctrl.br_kind = decode_pkg::br_jimm;
        if (inst_jr | inst_jalr) ctrl.br_kind = decode_pkg::br_jreg;

        // fetch fault outranks anything found in the word
        ctrl.exc      = 1'b1;
        ctrl.exc_code = 5'd0;
        if (pkt.adel) ctrl.exc_code = decode_pkg::exc_adel;
        else if (inst_break) ctrl.exc_code = decode_pkg::exc_bp;
        else if (inst_syscall) ctrl.exc_code = decode_pkg::exc_sys;
        else if (reserved) ctrl.exc_code = decode_pkg::exc_ri;
        else ctrl.exc = 1'b0;
    end

endmodule

//--- hdl/operand_fetch.sv
`timescale 1ns/1ps

module operand_fetch (
    input  logic                                clk,
    input  logic [decode_pkg::reg_addr_w-1:0]   rs_addr,
    input  logic [decode_pkg::reg_addr_w-1:0]   rt_addr,
    input  decode_pkg::wb_write_t               wb,
    input  decode_pkg::fwd_t                    fwd,
    output logic [decode_pkg::xlen-1:0]         rs_value,
    output logic [decode_pkg::xlen-1:0]         rt_value
);

    logic [decode_pkg::xlen-1:0] regs [2**decode_pkg::reg_addr_w];
    logic [decode_pkg::xlen-1:0] rs_rdata;
    logic [decode_pkg::xlen-1:0] rt_rdata;

    always_ff @(posedge clk) begin
        if (wb.we) begin
            regs[wb.addr] <= wb.data;
        end
    end

    // r0 is hardwired to zero whatever was written
    assign rs_rdata = (rs_addr == '0) ? '0 : regs[rs_addr];
    assign rt_rdata = (rt_addr == '0) ? '0 : regs[rt_addr];

    // same-cycle write-back and later results come in on fwd
    assign rs_value = fwd.rs_sel ? fwd.data : rs_rdata;
    assign rt_value = fwd.rt_sel ? fwd.data : rt_rdata;

endmodule

//--- hdl/branch_unit.sv
`timescale 1ns/1ps

module branch_unit (
    input  logic                        valid,
    input  decode_pkg::br_kind_e        kind,
    input  logic [decode_pkg::xlen-1:0] pc,
    input  logic [15:0]                 imm,
    input  logic [25:0]                 jidx,
    input  logic [decode_pkg::xlen-1:0] rs_value,
    input  logic [decode_pkg::xlen-1:0] rt_value,
    output decode_pkg::branch_t         br
);

    logic [decode_pkg::xlen-1:0] pc_plus4;
    logic [decode_pkg::xlen-1:0] rel_target;
    logic rs_eq_rt;
    logic rs_eq_0;
    logic rs_lt_0;
    logic rs_gt_0;
    logic cond;

    assign pc_plus4   = pc + 32'd4;
    assign rel_target = pc_plus4 + {{14{imm[15]}}, imm, 2'b00};

    assign rs_eq_rt = (rs_value == rt_value);
    assign rs_eq_0  = (rs_value == '0);
    assign rs_lt_0  = rs_value[decode_pkg::xlen-1];
    assign rs_gt_0  = ~rs_lt_0 & ~rs_eq_0;

    always_comb begin
        cond      = 1'b0;
        br.target = rel_target;
        case (kind)
            decode_pkg::br_beq:  cond = rs_eq_rt;
            decode_pkg::br_bne:  cond = ~rs_eq_rt;
            decode_pkg::br_bgez: cond = ~rs_lt_0;
            decode_pkg::br_bltz: cond = rs_lt_0;
            decode_pkg::br_bgtz: cond = rs_gt_0;
            decode_pkg::br_blez: cond = rs_lt_0 | rs_eq_0;
            decode_pkg::br_jimm: begin
                cond      = 1'b1;
                br.target = {pc_plus4[31:28], jidx, 2'b00};
            end
            decode_pkg::br_jreg: begin
                cond      = 1'b1;
                br.target = rs_value;
            end
            default: cond = 1'b0;
        endcase
        br.taken = cond & valid;
    end

endmodule

//--- hdl/id_stage.sv
`timescale 1ns/1ps

module id_stage (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   flush,
    input  logic                   fs_valid,
    output logic                   fs_ready,
    input  decode_pkg::fetch_pkt_t fs_pkt,
    output logic                   es_valid,
    input  logic                   es_ready,
    output decode_pkg::ex_pkt_t    es_pkt,
    input  decode_pkg::wb_write_t  wb,
    input  decode_pkg::fwd_t       fwd,
    output decode_pkg::branch_t    br
);

    decode_pkg::fetch_pkt_t      ds_pkt;
    decode_pkg::dec_ctrl_t       ctrl;
    logic [decode_pkg::xlen-1:0] rs_value;
    logic [decode_pkg::xlen-1:0] rt_value;

    decode_pipe_reg u_pipe_reg (
        .clk       (clk),
        .reset     (reset),
        .flush     (flush),
        .in_valid  (fs_valid),
        .in_ready  (fs_ready),
        .in_pkt    (fs_pkt),
        .out_valid (es_valid),
        .out_ready (es_ready),
        .out_pkt   (ds_pkt)
    );

    inst_decoder u_decoder (
        .pkt  (ds_pkt),
        .ctrl (ctrl)
    );

    operand_fetch u_operands (
        .clk      (clk),
        .rs_addr  (ds_pkt.inst[25:21]),
        .rt_addr  (ds_pkt.inst[20:16]),
        .wb       (wb),
        .fwd      (fwd),
        .rs_value (rs_value),
        .rt_value (rt_value)
    );

    branch_unit u_branch (
        .valid    (es_valid),
        .kind     (ctrl.br_kind),
        .pc       (ds_pkt.pc),
        .imm      (ctrl.imm),
        .jidx     (ds_pkt.inst[25:0]),
        .rs_value (rs_value),
        .rt_value (rt_value),
        .br       (br)
    );

    assign es_pkt = '{ctrl: ctrl, rs_value: rs_value, rt_value: rt_value, pc: ds_pkt.pc};

endmodule

//--- dv/id_stage_checker.sv
`timescale 1ns/1ps

module id_stage_checker (
    input  logic                clk,
    input  logic                reset,
    input  logic                flush,
    input  logic                fs_ready,
    input  logic                es_valid,
    input  logic                es_ready,
    input  decode_pkg::ex_pkt_t es_pkt,
    input  decode_pkg::branch_t br,
    input  logic [95:0]         test_name,
    input  logic                flush_test,
    input  decode_pkg::ex_pkt_t exp_pkt,
    input  decode_pkg::branch_t exp_br,
    output int                  test_count,
    output int                  fail_count
);

    decode_pkg::ex_pkt_t held;
    logic                holding;
    logic                stall_bad;
    logic                flush_seen;
    logic                idle_bad;

    function automatic string name_text(input logic [95:0] v);
        string s;
        s = "";
        for (int i = 11; i >= 0; i--) begin
            if (v[8*i +: 8] != 8'h00) begin
                s = {s, $sformatf("%c", v[8*i +: 8])};
            end
        end
        return s;
    endfunction

    // keeps only the first mismatch of a test
    task automatic check_field(input string field, input logic [31:0] exp_v,
                               input logic [31:0] act_v, inout string msg);
        if (msg == "" && exp_v !== act_v) begin
            msg = $sformatf("Fail %s: %s expected %h actual %h",
                            name_text(test_name), field, exp_v, act_v);
        end
    endtask

    task automatic record_result(input string msg);
        test_count++;
        if (msg == "") begin
            $display("Pass %s", name_text(test_name));
        end else begin
            fail_count++;
            $display("%s", msg);
        end
    endtask

    task automatic check_transfer();
        string msg;
        msg = "";
        check_field("alu_op", exp_pkt.ctrl.alu_op, es_pkt.ctrl.alu_op, msg);
        check_field("src1_is_sa", exp_pkt.ctrl.src1_is_sa, es_pkt.ctrl.src1_is_sa, msg);
        check_field("src1_is_pc", exp_pkt.ctrl.src1_is_pc, es_pkt.ctrl.src1_is_pc, msg);
        check_field("src2_sel", exp_pkt.ctrl.src2_sel, es_pkt.ctrl.src2_sel, msg);
        check_field("dest", exp_pkt.ctrl.dest, es_pkt.ctrl.dest, msg);
        check_field("gr_we", exp_pkt.ctrl.gr_we, es_pkt.ctrl.gr_we, msg);
        check_field("exc", exp_pkt.ctrl.exc, es_pkt.ctrl.exc, msg);
        check_field("exc_code", exp_pkt.ctrl.exc_code, es_pkt.ctrl.exc_code, msg);
        check_field("rs_value", exp_pkt.rs_value, es_pkt.rs_value, msg);
        check_field("rt_value", exp_pkt.rt_value, es_pkt.rt_value, msg);
        check_field("pc", exp_pkt.pc, es_pkt.pc, msg);
        check_field("br.taken", exp_br.taken, br.taken, msg);
        // target only matters when the branch goes
        if (exp_br.taken) begin
            check_field("br.target", exp_br.target, br.target, msg);
        end
        if (msg == "" && stall_bad) begin
            msg = $sformatf("Fail %s: es_pkt changed or fs_ready was high while stalled",
                            name_text(test_name));
        end
        if (msg == "" && idle_bad) begin
            msg = $sformatf("Fail %s: br.taken was high while es_valid was low",
                            name_text(test_name));
        end
        record_result(msg);
    endtask

    task automatic print_totals();
        $display("tests run %0d, passed %0d, failed %0d",
                 test_count, test_count - fail_count, fail_count);
    endtask

    always @(posedge clk) begin
        if (reset) begin
            holding    = 1'b0;
            stall_bad  = 1'b0;
            flush_seen = 1'b0;
            idle_bad   = 1'b0;
            test_count = 0;
            fail_count = 0;
        end else begin
            // one cycle after the flush edge the stage must be empty
            if (flush_seen) begin
                if (es_valid) begin
                    record_result({"Fail ", name_text(test_name),
                                   ": es_valid still high after flush"});
                end else begin
                    record_result("");
                end
                flush_seen = 1'b0;
                stall_bad  = 1'b0;
            end
            if (es_valid && es_ready) begin
                if (holding && es_pkt !== held) begin
                    stall_bad = 1'b1;
                end
                if (flush_test) begin
                    record_result({"Fail ", name_text(test_name),
                                   ": a flushed packet was transferred"});
                end else begin
                    check_transfer();
                end
                holding   = 1'b0;
                stall_bad = 1'b0;
                idle_bad  = 1'b0;
            end else if (es_valid) begin
                if (fs_ready) begin
                    stall_bad = 1'b1;
                end
                if (!holding) begin
                    held    = es_pkt;
                    holding = 1'b1;
                end else if (es_pkt !== held) begin
                    stall_bad = 1'b1;
                end
                if (flush && flush_test) begin
                    flush_seen = 1'b1;
                end
            end else begin
                holding = 1'b0;
                // an empty stage must not redirect fetch
                if (br.taken === 1'b1) begin
                    idle_bad = 1'b1;
                end
            end
        end
    end

endmodule

//--- dv/id_stage_tb.sv
`timescale 1ns/1ps

module id_stage_tb;

    typedef struct packed {
        logic [95:0]         name;
        logic [31:0]         pc;
        logic [31:0]         inst;
        logic                adel;
        logic [4:0]          w0;
        logic [4:0]          w1;
        decode_pkg::fwd_t    fwd;
        logic [3:0]          stall;
        logic                flush;
        decode_pkg::ex_pkt_t exp;
        decode_pkg::branch_t exp_br;
    } test_t;

    logic                   clk = 1'b0;
    logic                   reset;
    logic                   flush;
    logic                   fs_valid;
    logic                   fs_ready;
    decode_pkg::fetch_pkt_t fs_pkt;
    logic                   es_valid;
    logic                   es_ready;
    decode_pkg::ex_pkt_t    es_pkt;
    decode_pkg::wb_write_t  wb;
    decode_pkg::fwd_t       fwd;
    decode_pkg::branch_t    br;

    test_t       tests [32];
    test_t       cur;
    int          n_tests = 0;
    int          cycles = 0;
    int          cycle_limit = 0;
    int          test_count;
    int          fail_count;
    // register file as seen from write-back
    logic [31:0] model [32];

    always #5 clk = ~clk;

    id_stage UUT (
        .clk      (clk),
        .reset    (reset),
        .flush    (flush),
        .fs_valid (fs_valid),
        .fs_ready (fs_ready),
        .fs_pkt   (fs_pkt),
        .es_valid (es_valid),
        .es_ready (es_ready),
        .es_pkt   (es_pkt),
        .wb       (wb),
        .fwd      (fwd),
        .br       (br)
    );

    id_stage_checker u_checker (
        .clk        (clk),
        .reset      (reset),
        .flush      (flush),
        .fs_ready   (fs_ready),
        .es_valid   (es_valid),
        .es_ready   (es_ready),
        .es_pkt     (es_pkt),
        .br         (br),
        .test_name  (cur.name),
        .flush_test (cur.flush),
        .exp_pkt    (cur.exp),
        .exp_br     (cur.exp_br),
        .test_count (test_count),
        .fail_count (fail_count)
    );

    function automatic logic [31:0] rtype_word(input logic [4:0] rs, input logic [4:0] rt,
                                               input logic [4:0] rd, input logic [4:0] sa,
                                               input logic [5:0] fn);
        return {decode_pkg::op_special, rs, rt, rd, sa, fn};
    endfunction

    function automatic logic [31:0] itype_word(input logic [5:0] op, input logic [4:0] rs,
                                               input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] jump_word(input logic [5:0] op, input logic [25:0] idx);
        return {op, idx};
    endfunction

    function automatic logic [31:0] expected_operand(input logic sel, input logic [4:0] addr,
                                                     input logic [31:0] fdata);
        if (sel) return fdata;
        if (addr == 5'd0) return 32'd0;
        return model[addr];
    endfunction

    // w0 or w1 of zero means no preload write
    task automatic add_test(input logic [95:0] nm, input logic [31:0] inst,
                            input logic [4:0] w0, input logic [4:0] w1,
                            input logic [1:0] fsel, input logic [31:0] fdata);
        tests[n_tests]      = '0;
        tests[n_tests].name = nm;
        tests[n_tests].pc   = 32'h8000_1000;
        tests[n_tests].inst = inst;
        tests[n_tests].w0   = w0;
        tests[n_tests].w1   = w1;
        tests[n_tests].fwd  = '{rs_sel: fsel[1], rt_sel: fsel[0], data: fdata};
        n_tests++;
    endtask

    task automatic set_expect(input decode_pkg::alu_op_e alu, input decode_pkg::src2_sel_e s2,
                              input logic [4:0] dest, input logic we, input logic [4:0] code);
        tests[n_tests-1].exp.ctrl.alu_op   = alu;
        tests[n_tests-1].exp.ctrl.src2_sel = s2;
        tests[n_tests-1].exp.ctrl.dest     = dest;
        tests[n_tests-1].exp.ctrl.gr_we    = we;
        tests[n_tests-1].exp.ctrl.exc      = (code != 5'd0);
        tests[n_tests-1].exp.ctrl.exc_code = code;
    endtask

    task automatic set_taken(input logic [31:0] target);
        tests[n_tests-1].exp_br = '{taken: 1'b1, target: target};
    endtask

    task automatic build_table();
        add_test("addu", rtype_word(1, 2, 3, 0, decode_pkg::fn_addu), 1, 2, 2'b00, 0);
        set_expect(decode_pkg::alu_add, decode_pkg::src2_reg, 3, 1, 0);
        add_test("sll", rtype_word(0, 9, 4, 5, decode_pkg::fn_sll), 9, 0, 2'b00, 0);
        set_expect(decode_pkg::alu_sll, decode_pkg::src2_reg, 4, 1, 0);
        tests[n_tests-1].exp.ctrl.src1_is_sa = 1'b1;
        add_test("ori", itype_word(decode_pkg::op_ori, 17, 10, 16'hbeef), 17, 10, 2'b00, 0);
        set_expect(decode_pkg::alu_or, decode_pkg::src2_uimm, 10, 1, 0);
        add_test("r0_read", rtype_word(0, 2, 5, 0, decode_pkg::fn_addu), 0, 0, 2'b00, 0);
        set_expect(decode_pkg::alu_add, decode_pkg::src2_reg, 5, 1, 0);

        add_test("fwd_rs", rtype_word(1, 2, 6, 0, decode_pkg::fn_subu), 0, 0, 2'b10,
                 32'h1234_5678);
        set_expect(decode_pkg::alu_sub, decode_pkg::src2_reg, 6, 1, 0);
        add_test("fwd_rt", rtype_word(1, 2, 7, 0, decode_pkg::fn_and), 0, 0, 2'b01,
                 32'h0bad_f00d);
        set_expect(decode_pkg::alu_and, decode_pkg::src2_reg, 7, 1, 0);

        // branch operands come in on fwd and pc+4 is 8000_1004
        add_test("beq_take", itype_word(decode_pkg::op_beq, 1, 1, 16'h0010), 0, 0, 2'b11, 5);
        set_expect(decode_pkg::alu_add, decode_pkg::src2_reg, 0, 0, 0);
        set_taken(32'h8000_1044);
        add_test("beq_skip", itype_word(decode_pkg::op_beq, 1, 0, 16'h0010), 0, 0, 2'b10, 5);
        set_expect(decode_pkg::alu_add, decode_pkg::src2_reg, 0, 0, 0);
        add_test("bne_take", itype_word(decode_pkg::op_bne, 1, 0, 16'hfff0), 0, 0, 2'b10, 5);
        set_expect(decode_pkg::alu_add, decode_pkg::src2_reg, 31, 0, 0);
        set_taken(32'h8000_0fc4);
        add_test("bne_skip", itype_word(decode_pkg::op_bne, 1, 1, 16'hfff0), 0, 0, 2'b11, 5);
        set_expect(decode_pkg::alu_add, decode_pkg::src2_reg, 31, 0, 0);
        add_test("bgez_take", itype_word(decode_pkg::op_regimm, 1, decode_pkg::rt_bgez,
                 16'h0010), 0, 0, 2'b10, 0);
        set_expect(decode_pkg::alu_add, decode_pkg::src2_reg, 0, 0, 0);
        set_taken(32'h8000_1044);
        add_test("bgez_skip", itype_word(decode_pkg::op_regimm, 1, decode_pkg::rt_bgez,
                 16'h0010), 0, 0, 2'b10, 32'h8000_0000);
        set_expect(decode_pkg::alu_add, decode_pkg::src2_reg, 0, 0, 0);
        add_test("bltz_take", itype_word(decode_pkg::op_regimm, 1, decode_pkg::rt_bltz,
                 16'hfff0), 0, 0, 2'b10, 32'hffff_fffc);
        set_expect(decode_pkg::alu_add, decode_pkg::src2_reg, 31, 0, 0);
        set_taken(32'h8000_0fc4);
        add_test("bltz_skip", itype_word(decode_pkg::op_regimm, 1, decode_pkg::rt_bltz,
                 16'hfff0), 0, 0, 2'b10, 0);
        set_expect(decode_pkg::alu_add, decode_pkg::src2_reg, 31, 0, 0);
        add_test("bgtz_take", itype_word(decode_pkg::op_bgtz, 1, 0, 16'h0010), 0, 0, 2'b10, 1);
        set_expect(decode_pkg::alu_add, decode_pkg::src2_reg, 0, 0, 0);
        set_taken(32'h8000_1044);
        add_test("bgtz_skip", itype_word(decode_pkg::op_bgtz, 1, 0, 16'h0010), 0, 0, 2'b10, 0);
        set_expect(decode_pkg::alu_add, decode_pkg::src2_reg, 0, 0, 0);
        add_test("blez_take", itype_word(decode_pkg::op_blez, 1, 0, 16'h0010), 0, 0, 2'b10, 0);
        set_expect(decode_pkg::alu_add, decode_pkg::src2_reg, 0, 0, 0);
        set_taken(32'h8000_1044);
        add_test("blez_skip", itype_word(decode_pkg::op_blez, 1, 0, 16'h0010), 0, 0, 2'b10, 7);
        set_expect(decode_pkg::alu_add, decode_pkg::src2_reg, 0, 0, 0);

        // index 000abcd leaves rs and rt at zero and rd at 21
        add_test("j", jump_word(decode_pkg::op_j, 26'h000abcd), 0, 0, 2'b00, 0);
        set_expect(decode_pkg::alu_add, decode_pkg::src2_reg, 21, 0, 0);
        set_taken(32'h8002_af34);
        add_test("jal", jump_word(decode_pkg::op_jal, 26'h000abcd), 0, 0, 2'b00, 0);
        set_expect(decode_pkg::alu_add, decode_pkg::src2_const8, 31, 1, 0);
        tests[n_tests-1].exp.ctrl.src1_is_pc = 1'b1;
        set_taken(32'h8002_af34);
        add_test("jr", rtype_word(1, 0, 0, 0, decode_pkg::fn_jr), 0, 0, 2'b10, 32'h8000_2000);
        set_expect(decode_pkg::alu_add, decode_pkg::src2_reg, 0, 0, 0);
        set_taken(32'h8000_2000);

        add_test("syscall", 32'h0000_000c, 0, 0, 2'b00, 0);
        set_expect(decode_pkg::alu_add, decode_pkg::src2_reg, 0, 0, decode_pkg::exc_sys);
        add_test("break", 32'h0000_000d, 0, 0, 2'b00, 0);
        set_expect(decode_pkg::alu_add, decode_pkg::src2_reg, 0, 0, decode_pkg::exc_bp);
        add_test("reserved", 32'hfc00_0000, 0, 0, 2'b00, 0);
        set_expect(decode_pkg::alu_add, decode_pkg::src2_reg, 0, 0, decode_pkg::exc_ri);
        add_test("adel_break", 32'h0000_000d, 0, 0, 2'b00, 0);
        tests[n_tests-1].adel = 1'b1;
        set_expect(decode_pkg::alu_add, decode_pkg::src2_reg, 0, 0, decode_pkg::exc_adel);

        add_test("stall_addiu", itype_word(decode_pkg::op_addiu, 1, 2, 16'h1234), 0, 0, 2'b00, 0);
        tests[n_tests-1].stall = 4'd5;
        set_expect(decode_pkg::alu_add, decode_pkg::src2_simm, 2, 1, 0);
        add_test("flush_or", rtype_word(1, 2, 11, 0, decode_pkg::fn_or), 0, 0, 2'b00, 0);
        tests[n_tests-1].flush = 1'b1;
    endtask

    task automatic write_reg(input logic [4:0] addr);
        logic [31:0] data;
        if (addr != 5'd0) begin
            data = $urandom;
            wb   = '{we: 1'b1, addr: addr, data: data};
            @(posedge clk) #1;
            wb.we       = 1'b0;
            model[addr] = data;
        end
    endtask

    task automatic run_test(input int idx);
        test_t t;
        t = tests[idx];
        write_reg(t.w0);
        write_reg(t.w1);
        t.exp.rs_value = expected_operand(t.fwd.rs_sel, t.inst[25:21], t.fwd.data);
        t.exp.rt_value = expected_operand(t.fwd.rt_sel, t.inst[20:16], t.fwd.data);
        t.exp.pc       = t.pc;
        cur      = t;
        fwd      = t.fwd;
        fs_pkt   = '{pc: t.pc, inst: t.inst, adel: t.adel};
        fs_valid = 1'b1;
        while (!fs_ready) @(posedge clk) #1;
        @(posedge clk) #1;
        fs_valid = 1'b0;
        if (t.flush) begin
            flush = 1'b1;
            @(posedge clk) #1;
            flush    = 1'b0;
            es_ready = 1'b1;
            @(posedge clk) #1;
            es_ready = 1'b0;
        end else begin
            // a second packet waits behind the stalled one
            if (t.stall != 0) begin
                fs_pkt   = '{pc: t.pc + 32'd4, inst: t.inst, adel: 1'b0};
                fs_valid = 1'b1;
            end
            repeat (t.stall) @(posedge clk) #1;
            fs_valid = 1'b0;
            es_ready = 1'b1;
            while (!es_valid) @(posedge clk) #1;
            @(posedge clk) #1;
            es_ready = 1'b0;
        end
    endtask

    initial begin
        void'($urandom(32'hf0f4_511d));
        reset    = 1'b1;
        flush    = 1'b0;
        fs_valid = 1'b0;
        fs_pkt   = '0;
        es_ready = 1'b0;
        wb       = '0;
        fwd      = '0;
        cur      = '0;
        build_table();
        for (int i = 0; i < n_tests; i++) begin
            cycle_limit += tests[i].stall + 4;
        end
        cycle_limit += 20;
        repeat (3) @(posedge clk);
        #1 reset = 1'b0;
        for (int i = 0; i < n_tests; i++) begin
            run_test(i);
        end
        u_checker.print_totals();
        if (fail_count == 0 && test_count == n_tests) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    initial begin
        #1;
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles, the run hung waiting for es_valid", cycles);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

//--- id_stage.f
hdl/decode_pkg.sv
hdl/decode_pipe_reg.sv
hdl/inst_decoder.sv
hdl/operand_fetch.sv
hdl/branch_unit.sv
hdl/id_stage.sv
dv/id_stage_checker.sv
dv/id_stage_tb.sv
